// ==== include/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// mmu geometry
`define FETCH_PAGE_WORDS 16  // words per page
`define FETCH_SEGMENTS 16  // physical segments

// one page per segment, so the word memory is the product
`define FETCH_MEM_WORDS (`FETCH_PAGE_WORDS * `FETCH_SEGMENTS)

`define FETCH_PROGRAM_START 8'h00  // first logical pc after reset

// trace path
`define FETCH_TRACE_DEPTH 8  // fifo entries
`define FETCH_CLK_PER_BIT 4  // short bit time for simulation

`endif

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  typedef logic [15:0] word_t;  // one memory word
  typedef logic [7:0] laddr_t;  // logical word address
  typedef logic [7:0] paddr_t;  // physical word address
  typedef logic [3:0] seg_t;  // segment index
  typedef logic [3:0] page_t;  // logical page number

  // one link of a process chain
  typedef struct packed {
    seg_t  next;  // equals own index at chain end
    page_t page;  // logical page held here
  } seg_entry_t;

  // segment table write
  typedef struct packed {
    seg_t       seg;
    seg_entry_t entry;
  } seg_load_t;

  // word memory write
  typedef struct packed {
    paddr_t addr;
    word_t  data;
  } mem_load_t;

  // fetched instruction pair
  typedef struct packed {
    laddr_t pc;  // address of word1
    word_t  word1;  // opcode in high byte
    word_t  word2;
  } instr_t;

endpackage

// ==== verilog/program_ram.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module program_ram (
  input  logic                 clk,
  input  logic                 load_en,
  input  fetch_pkg::mem_load_t load,
  input  fetch_pkg::paddr_t    rd_addr,
  output fetch_pkg::word_t     rd_data
);
  import fetch_pkg::*;

  word_t mem_q [`FETCH_MEM_WORDS];  // whole physical space

  // write port, filled by the testbench before run
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem_q[load.addr] <= load.data;
    end
  end

  // registered read, data one cycle after address
  always_ff @(posedge clk) begin
    rd_data <= mem_q[rd_addr];
  end

endmodule

// ==== verilog/mmu_walker.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module mmu_walker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 seg_load_en,
  input  fetch_pkg::seg_load_t seg_load,
  input  fetch_pkg::seg_t      start_segment,
  input  logic                 xlat_req,
  input  fetch_pkg::laddr_t    xlat_addr,
  output logic                 xlat_done,
  output logic                 xlat_fault,
  output fetch_pkg::paddr_t    xlat_paddr
);
  import fetch_pkg::*;

  localparam int off_w = $clog2(`FETCH_PAGE_WORDS);

  typedef enum logic {st_idle, st_walk} state_t;

  seg_entry_t       seg_table_q [`FETCH_SEGMENTS];
  state_t           state_q;
  seg_t             cur_q;  // segment under test
  page_t            page_q;  // page being looked for
  logic [off_w-1:0] off_q;
  page_t            req_page;
  logic [off_w-1:0] req_off;
  seg_entry_t       cur_entry;
  logic             hit;
  logic             chain_end;

  function automatic paddr_t phys(input seg_t seg, input logic [off_w-1:0] off);
    return paddr_t'(seg * `FETCH_PAGE_WORDS + off);
  endfunction

  assign req_page  = page_t'(xlat_addr / `FETCH_PAGE_WORDS);
  assign req_off   = off_w'(xlat_addr % `FETCH_PAGE_WORDS);
  assign cur_entry = seg_table_q[cur_q];
  assign hit       = (cur_entry.page == page_q);
  assign chain_end = (cur_entry.next == cur_q);  // self link closes the chain

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= st_idle;
      xlat_done  <= 1'b0;
      xlat_fault <= 1'b0;
      for (int i = 0; i < `FETCH_SEGMENTS; i++) begin
        seg_table_q[i].next <= seg_t'(i);  // every segment its own chain end
        seg_table_q[i].page <= '0;
      end
    end else begin
      xlat_done  <= 1'b0;  // pulses
      xlat_fault <= 1'b0;
      if (seg_load_en) begin
        seg_table_q[seg_load.seg] <= seg_load.entry;
      end
      case (state_q)
        st_idle: begin
          if (xlat_req) begin
            if (req_page == '0) begin
              xlat_done <= 1'b1;  // page 0 lives at start_segment, no walk
            end else begin
              state_q <= st_walk;
            end
          end
        end
        st_walk: begin
          if (hit) begin
            xlat_done <= 1'b1;
            state_q   <= st_idle;
          end else if (chain_end) begin
            xlat_fault <= 1'b1;  // page not mapped in this chain
            state_q    <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // walk datapath, one chain entry per clock
  always_ff @(posedge clk) begin
    if (state_q == st_idle && xlat_req) begin
      page_q     <= req_page;
      off_q      <= req_off;
      cur_q      <= start_segment;  // walk starts at the chain head
      xlat_paddr <= phys(start_segment, req_off);  // page 0 answer
    end else if (state_q == st_walk) begin
      cur_q      <= cur_entry.next;
      xlat_paddr <= phys(cur_q, off_q);  // taken only on a hit
    end
  end

endmodule

// ==== verilog/fetch_sequencer.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module fetch_sequencer (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,
  output logic              xlat_req,
  output fetch_pkg::laddr_t xlat_addr,
  input  logic              xlat_done,
  input  logic              xlat_fault,
  input  fetch_pkg::paddr_t xlat_paddr,
  output fetch_pkg::paddr_t rd_addr,
  input  fetch_pkg::word_t  rd_data,
  input  logic              trace_full,
  output logic              trace_push,
  output logic [7:0]        trace_byte,
  output logic              instr_valid,
  output fetch_pkg::instr_t instr,
  output logic              fault
);
  import fetch_pkg::*;

  typedef enum logic [2:0] {
    s_xlat1, s_read1, s_xlat2, s_read2, s_emit, s_halt
  } state_t;

  state_t state_q;
  logic   busy_q;  // request sent or read under way
  laddr_t pc_q;
  logic   xlat_state;

  assign xlat_state = (state_q == s_xlat1) || (state_q == s_xlat2);
  assign xlat_addr  = (state_q == s_xlat2) ? pc_q + laddr_t'(1) : pc_q;
  assign trace_byte = instr.word1[15:8];  // opcode byte

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= s_xlat1;
      busy_q      <= 1'b0;
      pc_q        <= laddr_t'(`FETCH_PROGRAM_START);
      fault       <= 1'b0;
      xlat_req    <= 1'b0;
      instr_valid <= 1'b0;
      trace_push  <= 1'b0;
    end else begin
      xlat_req    <= 1'b0;
      instr_valid <= 1'b0;
      trace_push  <= 1'b0;
      case (state_q)
        s_xlat1, s_xlat2: begin
          if (!busy_q) begin
            if (run || state_q == s_xlat2) begin  // run only gates a new pair
              xlat_req <= 1'b1;
              busy_q   <= 1'b1;
            end
          end else if (xlat_fault) begin
            fault   <= 1'b1;  // held until reset
            state_q <= s_halt;
          end else if (xlat_done) begin
            busy_q  <= 1'b0;
            state_q <= (state_q == s_xlat1) ? s_read1 : s_read2;
          end
        end
        s_read1, s_read2: begin
          busy_q <= !busy_q;  // wait one cycle for ram data
          if (busy_q) begin
            state_q <= (state_q == s_read1) ? s_xlat2 : s_emit;
          end
        end
        s_emit: begin
          if (!trace_full) begin  // hold the pair until the fifo has room
            instr_valid <= 1'b1;
            trace_push  <= 1'b1;
            pc_q        <= pc_q + laddr_t'(2);
            state_q     <= s_xlat1;
          end
        end
        s_halt: state_q <= s_halt;
        default: state_q <= s_halt;
      endcase
    end
  end

  // pair and read address
  always_ff @(posedge clk) begin
    if (state_q == s_xlat1 && !busy_q && run) begin
      instr.pc <= pc_q;
    end
    if (xlat_state && busy_q && xlat_done) begin
      rd_addr <= xlat_paddr;
    end
    if (state_q == s_read1 && busy_q) begin
      instr.word1 <= rd_data;
    end
    if (state_q == s_read2 && busy_q) begin
      instr.word2 <= rd_data;
    end
  end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps

// 8N1, lsb first, line idles high
module uart_tx #(
  parameter int clk_per_bit = 868  // 100 MHz at 115200 baud
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       idle,
  output logic       tx
);

  localparam int cnt_w = (clk_per_bit > 1) ? $clog2(clk_per_bit) : 1;

  localparam logic [3:0] st_idle  = 4'd0;
  localparam logic [3:0] st_start = 4'd1;
  localparam logic [3:0] st_bit0  = 4'd2;  // data bits 2..9
  localparam logic [3:0] st_stop  = 4'd10;

  logic [3:0]       state_q;
  logic [cnt_w-1:0] cnt_q;  // clocks left in this bit
  logic [7:0]       data_q;

  assign idle = (state_q == st_idle);

  always_comb begin
    if (state_q == st_idle || state_q == st_stop) begin
      tx = 1'b1;
    end else if (state_q == st_start) begin
      tx = 1'b0;
    end else begin
      tx = data_q[3'(state_q - st_bit0)];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else if (state_q == st_idle) begin
      if (start) begin
        state_q <= st_start;
        cnt_q   <= cnt_w'(clk_per_bit - 1);
      end
    end else if (cnt_q == '0) begin
      state_q <= (state_q == st_stop) ? st_idle : state_q + 4'd1;  // next bit
      cnt_q   <= cnt_w'(clk_per_bit - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // frame byte, stable for the whole frame
  always_ff @(posedge clk) begin
    if (state_q == st_idle && start) begin
      data_q <= data;
    end
  end

endmodule

// ==== verilog/trace_buffer.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module trace_buffer #(
  parameter int clk_per_bit = `FETCH_CLK_PER_BIT
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  logic [7:0] push_byte,
  output logic       full,
  output logic       tx
);

  localparam int depth = `FETCH_TRACE_DEPTH;
  localparam int ptr_w = $clog2(depth);

  logic [7:0]       fifo_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;
  logic             tx_idle;
  logic             do_push;
  logic             pop;

  assign full    = (count_q == (ptr_w + 1)'(depth));
  assign do_push = push && !full;  // sequencer waits on full, never drops
  assign pop     = tx_idle && (count_q != '0);  // hand next byte to the transmitter

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      fifo_q[wr_ptr_q] <= push_byte;
    end
  end

  uart_tx #(
    .clk_per_bit(clk_per_bit)
  ) u_uart_tx (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (pop),
    .data   (fifo_q[rd_ptr_q]),
    .idle   (tx_idle),
    .tx     (tx)
  );

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module fetch_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 mem_load_en,
  input  fetch_pkg::mem_load_t mem_load,
  input  logic                 seg_load_en,
  input  fetch_pkg::seg_load_t seg_load,
  input  fetch_pkg::seg_t      start_segment,
  input  logic                 run,
  output logic                 instr_valid,
  output fetch_pkg::instr_t    instr,
  output logic                 fault,
  output logic                 tx
);
  import fetch_pkg::*;

  // sequencer to mmu
  logic   xlat_req;
  laddr_t xlat_addr;
  logic   xlat_done;
  logic   xlat_fault;
  paddr_t xlat_paddr;

  // sequencer to ram
  paddr_t rd_addr;
  word_t  rd_data;

  // sequencer to trace fifo
  logic       trace_full;
  logic       trace_push;
  logic [7:0] trace_byte;

  program_ram u_program_ram (
    .clk     (clk),
    .load_en (mem_load_en),
    .load    (mem_load),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  mmu_walker u_mmu_walker (
    .clk           (clk),
    .arst_n        (arst_n),
    .seg_load_en   (seg_load_en),
    .seg_load      (seg_load),
    .start_segment (start_segment),
    .xlat_req      (xlat_req),
    .xlat_addr     (xlat_addr),
    .xlat_done     (xlat_done),
    .xlat_fault    (xlat_fault),
    .xlat_paddr    (xlat_paddr)
  );

  fetch_sequencer u_fetch_sequencer (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .xlat_req    (xlat_req),
    .xlat_addr   (xlat_addr),
    .xlat_done   (xlat_done),
    .xlat_fault  (xlat_fault),
    .xlat_paddr  (xlat_paddr),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .trace_full  (trace_full),
    .trace_push  (trace_push),
    .trace_byte  (trace_byte),
    .instr_valid (instr_valid),
    .instr       (instr),
    .fault       (fault)
  );

  trace_buffer #(
    .clk_per_bit(`FETCH_CLK_PER_BIT)
  ) u_trace_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (trace_push),
    .push_byte (trace_byte),
    .full      (trace_full),
    .tx        (tx)
  );

endmodule

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int rec_words  = 4;  // kind plus three fields per record
  localparam int stim_words = 256;
  localparam int frame_clks = 10 * `FETCH_CLK_PER_BIT;  // start bit, 8 data bits and stop bit

  logic      clk;
  logic      arst_n;
  logic      mem_load_en;
  mem_load_t mem_load;
  logic      seg_load_en;
  seg_load_t seg_load;
  seg_t      start_segment;
  logic      run;
  logic      instr_valid;
  instr_t    instr;
  logic      fault;
  logic      tx;

  logic [15:0] stim [stim_words];
  word_t       image [`FETCH_MEM_WORDS];  // model copy of the program memory
  seg_entry_t  table_m [`FETCH_SEGMENTS];  // model copy of the segment table
  instr_t      exp_instr [$];
  logic [7:0]  exp_bytes [$];
  logic [7:0]  rx_bytes [$];  // filled by the line decoder
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  fetch_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_load_en   (mem_load_en),
    .mem_load      (mem_load),
    .seg_load_en   (seg_load_en),
    .seg_load      (seg_load),
    .start_segment (start_segment),
    .run           (run),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .fault         (fault),
    .tx            (tx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic check_instr(input int idx, input instr_t got, input instr_t want);
    if (got !== want) begin
      $display("CHECK FAILED instr[%0d]: got %h expected %h", idx, got, want);
      errors++;
    end
  endtask

  task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] want);
    if (got !== want) begin
      $display("CHECK FAILED trace byte %0d: got %h expected %h", idx, got, want);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  // chain walk model, returns 0 when the chain ends without a match
  function automatic bit translate(input seg_t start, input laddr_t la, output paddr_t pa);
    page_t pg;
    seg_t  seg;
    bit    found;
    bit    ended;
    pg    = page_t'(la / `FETCH_PAGE_WORDS);
    seg   = start;
    found = (pg == '0);  // page 0 sits at the start segment
    ended = 1'b0;
    for (int i = 0; i < `FETCH_SEGMENTS && !found && !ended; i++) begin
      if (table_m[seg].page == pg) begin
        found = 1'b1;
      end else if (table_m[seg].next == seg) begin
        ended = 1'b1;  // self link ends the chain without a match
      end else begin
        seg = table_m[seg].next;
      end
    end
    pa = paddr_t'(seg * `FETCH_PAGE_WORDS + la % `FETCH_PAGE_WORDS);
    return found;
  endfunction

  // expected pairs and opcode bytes up to n pairs or the first fault
  function automatic void build_expected(input seg_t start, input int n, output bit model_fault);
    laddr_t pc;
    paddr_t pa1;
    paddr_t pa2;
    bit     ok1;
    bit     ok2;
    instr_t e;
    pc          = laddr_t'(`FETCH_PROGRAM_START);
    model_fault = 1'b0;
    exp_instr.delete();
    exp_bytes.delete();
    for (int i = 0; i < n && !model_fault; i++) begin
      ok1 = translate(start, pc, pa1);
      ok2 = translate(start, pc + laddr_t'(1), pa2);
      if (!ok1 || !ok2) begin
        model_fault = 1'b1;
      end else begin
        e.pc    = pc;
        e.word1 = image[pa1];
        e.word2 = image[pa2];
        exp_instr.push_back(e);
        exp_bytes.push_back(e.word1[15:8]);  // opcode byte
        pc = pc + laddr_t'(2);
      end
    end
  endfunction

  // cycle budget from the pair counts in the input file
  function automatic int run_limit();
    int lim;
    int i;
    lim = 0;
    i   = 0;
    while (i <= stim_words - rec_words && stim[i] inside {16'h1, 16'h2, 16'h3}) begin
      if (stim[i] == 16'h1) begin
        lim += int'(stim[i + 2]) * (frame_clks + 64) + `FETCH_MEM_WORDS + 4 * frame_clks + 200;
      end
      i += rec_words;
    end
    return lim;
  endfunction

  task automatic reset_dut();
    @(negedge clk);
    arst_n = 1'b0;
    run    = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int s = 0; s < `FETCH_SEGMENTS; s++) begin
      table_m[s].next = seg_t'(s);  // table reset state
      table_m[s].page = '0;
    end
  endtask

  task automatic load_segment(input seg_t s, input seg_t nxt, input page_t pg);
    seg_load.seg        = s;
    seg_load.entry.next = nxt;
    seg_load.entry.page = pg;
    seg_load_en         = 1'b1;
    table_m[s]          = seg_load.entry;
    @(negedge clk);
    seg_load_en = 1'b0;
  endtask

  task automatic load_image();
    for (int a = 0; a < `FETCH_MEM_WORDS; a++) begin
      mem_load.addr = paddr_t'(a);
      mem_load.data = image[a];
      mem_load_en   = 1'b1;
      @(negedge clk);  // written on the posedge between
    end
    mem_load_en = 1'b0;
  endtask

  task automatic fetch_and_check(input seg_t start, input int n, input logic want_fault,
                                 output int got);
    bit model_fault;
    bit done;
    build_expected(start, n, model_fault);
    if (model_fault != want_fault) begin
      $display("input file expects fault %0b but the chain walk model gives %0b",
               want_fault, model_fault);
      errors++;
    end
    rx_bytes.delete();
    got  = 0;
    done = 1'b0;
    run  = 1'b1;
    while (!done) begin
      @(negedge clk);
      if (instr_valid) begin
        if (got < exp_instr.size()) begin
          check_instr(got, instr, exp_instr[got]);
        end else begin
          $display("instr_valid pulse %0d has no expected pair", got);
          errors++;
        end
        got++;
      end
      done = fault || (!model_fault && got == exp_instr.size());
    end
    if (!model_fault) begin
      run = 1'b0;  // stops before the next pair starts
    end
    // after a fault run stays high, so only the halt keeps the sequencer quiet
    while (rx_bytes.size() < got) begin  // drain the trace line
      @(negedge clk);
      if (instr_valid) got++;
    end
    repeat (2 * frame_clks) begin  // nothing more may appear in this window
      @(negedge clk);
      if (instr_valid) got++;
    end
    run = 1'b0;
    check_level("fault", fault, want_fault);
    if (got != exp_instr.size()) begin
      $display("expected %0d instr_valid pulses but saw %0d", exp_instr.size(), got);
      errors++;
    end
    if (rx_bytes.size() != exp_bytes.size()) begin
      $display("expected %0d trace bytes but decoded %0d", exp_bytes.size(), rx_bytes.size());
      errors++;
    end
    for (int i = 0; i < rx_bytes.size() && i < exp_bytes.size(); i++) begin
      check_byte(i, rx_bytes[i], exp_bytes[i]);
    end
  endtask

  // 8N1 decoder sampling mid-bit on falling clock edges
  initial begin : line_decoder
    logic [7:0] b;
    logic       start_ok;
    forever begin
      @(negedge clk);
      if (arst_n === 1'b1 && tx === 1'b0) begin
        repeat (`FETCH_CLK_PER_BIT / 2) @(negedge clk);
        start_ok = (tx === 1'b0);
        for (int i = 0; i < 8; i++) begin
          repeat (`FETCH_CLK_PER_BIT) @(negedge clk);
          b[i] = tx;  // lsb first
        end
        repeat (`FETCH_CLK_PER_BIT) @(negedge clk);
        if (!start_ok || tx !== 1'b1) begin
          $display("trace line frame %0d has a bad start or stop bit", rx_bytes.size());
          errors++;
        end
        rx_bytes.push_back(b);
      end
    end
  end

  initial begin : watchdog
    while (cycle_limit == 0 || cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles without finishing", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int       idx;
    int       n;
    int       got;
    int       tests;
    int       passed;
    int       err_before;
    seg_t     start;
    logic     want_fault;
    arst_n        = 1'b0;
    mem_load_en   = 1'b0;
    mem_load      = '0;
    seg_load_en   = 1'b0;
    seg_load      = '0;
    start_segment = '0;
    run           = 1'b0;
    void'($urandom(69061));  // single seed for the run
    $readmemh("testbench/fetch_input.txt", stim);
    cycle_limit = run_limit() + 1000;
    idx    = 0;
    tests  = 0;
    passed = 0;
    while (idx <= stim_words - rec_words && stim[idx] == 16'h1) begin
      start      = seg_t'(stim[idx + 1]);
      n          = int'(stim[idx + 2]);
      want_fault = stim[idx + 3][0];
      idx += rec_words;
      err_before    = errors;
      start_segment = start;
      reset_dut();
      check_level("instr_valid", instr_valid, 1'b0);  // idle before run
      check_level("fault", fault, 1'b0);
      check_level("tx", tx, 1'b1);
      for (int a = 0; a < `FETCH_MEM_WORDS; a++) begin
        image[a] = word_t'($urandom());  // filler
      end
      while (idx <= stim_words - rec_words && (stim[idx] == 16'h2 || stim[idx] == 16'h3)) begin
        if (stim[idx] == 16'h2) begin
          load_segment(seg_t'(stim[idx + 1]), seg_t'(stim[idx + 2]), page_t'(stim[idx + 3]));
        end else begin
          image[paddr_t'(stim[idx + 1])] = stim[idx + 2];  // fixed word over the filler
        end
        idx += rec_words;
      end
      load_image();
      fetch_and_check(start, n, want_fault, got);
      tests++;
      if (errors == err_before) passed++;
      $display("test %0d: start segment %h, %0d pairs, fault %0b, %0d errors, %s",
               tests, start, got, fault, errors - err_before,
               (errors == err_before) ? "pass" : "fail");
    end
    if (tests == 0) begin
      $display("no test records read from the input file");
      errors++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests, passed, tests - passed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/fetch_input.txt ====
// columns: kind a b c, all hex
// kind 1 test: start segment, pair count, fault; 2 segment: index, next, page; 3 word: addr, data
// page 0 only, start segment 5
1 5 8 0
3 50 a1b2 0
3 51 0042 0
3 5e 7f00 0
// chain 3 -> 9 -> c -> 7, pages 0 2 1 3, long enough to fill the trace fifo
1 3 20 0
2 3 9 0
2 9 c 2
2 c 7 1
2 7 7 3
3 30 1234 0
3 c0 5a5a 0
3 90 c3c3 0
3 70 ff01 0
// chain 2 -> 6 maps pages 0 and 1, page 2 runs off the chain end
1 2 14 1
2 2 6 0
2 6 6 1
3 20 0e0e 0
3 60 6161 0
3 6f 6f6f 0
0 0 0 0

// ==== all.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/program_ram.sv
verilog/mmu_walker.sv
verilog/fetch_sequencer.sv
verilog/uart_tx.sv
verilog/trace_buffer.sv
verilog/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_fetch_top -o tb_fetch_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_fetch_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0
